/* hdl/FxpPkg.sv */
package FxpPkg;

    // Two's complement format with sign, integer and fraction bits
    localparam int nInt = 8;
    localparam int nMant = 23;
    localparam int width = nInt + nMant + 1;

    typedef logic signed [width-1:0] FxpValue;

    typedef struct packed {
        FxpValue re;
        FxpValue im;
    } CplxFxp;

    typedef enum logic {
        opAdd,
        opMult
    } FxpOp;

    // Real product at double width, then back to the fixed-point grid by truncation
    function automatic FxpValue fxpMul(FxpValue a, FxpValue b);
        logic signed [2*width-1:0] prod;
        prod = a * b;
        prod = prod >>> nMant;
        return prod[width-1:0];
    endfunction

    function automatic CplxFxp cAdd(CplxFxp a, CplxFxp b);
        CplxFxp sum;
        sum.re = a.re + b.re;
        sum.im = a.im + b.im;
        return sum;
    endfunction

    function automatic CplxFxp cMul(CplxFxp a, CplxFxp b);
        CplxFxp prod;
        prod.re = fxpMul(a.re, b.re) - fxpMul(a.im, b.im);
        prod.im = fxpMul(a.re, b.im) + fxpMul(a.im, b.re);
        return prod;
    endfunction

endpackage

/* hdl/RecursionPkg.sv */
package RecursionPkg;

    localparam int maxRows = 8;
    localparam int maxBits = 32;

    // Builds a complex constant from values given in thousandths
    function automatic FxpPkg::CplxFxp cplxMilli(int re, int im);
        FxpPkg::CplxFxp c;
        c.re = FxpPkg::FxpValue'((longint'(re) <<< FxpPkg::nMant) / 1000);
        c.im = FxpPkg::FxpValue'((longint'(im) <<< FxpPkg::nMant) / 1000);
        return c;
    endfunction

    // Recursion factors, all inside the unit circle
    localparam FxpPkg::CplxFxp lookbackFactor [maxRows] = '{
        cplxMilli(900, 100), cplxMilli(850, -200),
        cplxMilli(700, 300), cplxMilli(600, -400),
        cplxMilli(500, 450), cplxMilli(400, -500),
        cplxMilli(300, 600), cplxMilli(200, -700)
    };

    localparam FxpPkg::CplxFxp outputWeight [maxRows] = '{
        cplxMilli(120, -30), cplxMilli(-80, 60),
        cplxMilli(50, 90), cplxMilli(-40, -70),
        cplxMilli(30, 20), cplxMilli(-25, 45),
        cplxMilli(15, -35), cplxMilli(10, 5)
    };

    // Input weight F for one row and bit, spread over roughly +-0.2
    function automatic FxpPkg::CplxFxp inputWeight(int row, int bitIdx);
        int k;
        k = row * maxBits + bitIdx;
        return cplxMilli(((k * 37) % 41 - 20) * 10, ((k * 23) % 37 - 18) * 10);
    endfunction

endpackage

/* hdl/ComplexFxpUnit.sv */
`timescale 1ns/1ps

module ComplexFxpUnit #(
    parameter FxpPkg::FxpOp op = FxpPkg::opAdd
) (
    input  logic           clkResult,
    input  logic           arstN,
    input  FxpPkg::CplxFxp a,
    input  FxpPkg::CplxFxp b,
    output FxpPkg::CplxFxp y
);

    FxpPkg::CplxFxp opResult;

    always_comb begin
        if (op == FxpPkg::opMult) begin
            opResult = FxpPkg::cMul(a, b);
        end else begin
            opResult = FxpPkg::cAdd(a, b);
        end
    end

    always_ff @(posedge clkResult or negedge arstN) begin
        if (!arstN) begin
            y <= '0;
        end else begin
            y <= opResult;
        end
    end

endmodule

/* hdl/LutUnit.sv */
`timescale 1ns/1ps

module LutUnit #(
    parameter int row = 0,
    parameter int numCtrl = 4,
    parameter int downSample = 3,
    parameter int lutSize = 4,
    localparam int sampleBits = numCtrl * downSample
) (
    input  logic                  clkResult,
    input  logic                  arstN,
    input  logic [sampleBits-1:0] sample,
    output FxpPkg::CplxFxp        y
);

    localparam int numGroups = (sampleBits + lutSize - 1) / lutSize;
    localparam int tableSize = 2 ** lutSize;

    // Sum of +F or -F over the bits of one group for one table index
    // Bit i of the reversed sample uses inputWeight(row, i)
    function automatic FxpPkg::CplxFxp groupSum(int group, int index);
        FxpPkg::CplxFxp acc;
        FxpPkg::CplxFxp f;
        int bitIdx;
        acc = '0;
        for (int b = 0; b < lutSize; b++) begin
            bitIdx = group * lutSize + b;
            if (bitIdx < sampleBits) begin
                f = RecursionPkg::inputWeight(row, bitIdx);
                if (!index[b]) begin
                    f.re = -f.re;
                    f.im = -f.im;
                end
                acc = FxpPkg::cAdd(acc, f);
            end
        end
        return acc;
    endfunction

    logic [sampleBits-1:0] reversed;
    logic [numGroups*lutSize-1:0] padded;
    FxpPkg::CplxFxp lutTable [numGroups][tableSize];
    FxpPkg::CplxFxp groupOut [numGroups];
    FxpPkg::CplxFxp total;

    // Reverse the sample order in steps of one control vector
    for (genvar j = 0; j < downSample; j++) begin : gReverse
        assign reversed[numCtrl*j +: numCtrl] = sample[numCtrl*(downSample-j-1) +: numCtrl];
    end

    // Last group may be partial, upper bits stay zero
    always_comb begin
        padded = '0;
        padded[sampleBits-1:0] = reversed;
    end

    for (genvar g = 0; g < numGroups; g++) begin : gGroup
        for (genvar v = 0; v < tableSize; v++) begin : gEntry
            assign lutTable[g][v] = groupSum(g, v);
        end
        assign groupOut[g] = lutTable[g][padded[g*lutSize +: lutSize]];
    end

    always_comb begin
        total = '0;
        for (int g = 0; g < numGroups; g++) begin
            total = FxpPkg::cAdd(total, groupOut[g]);
        end
    end

    always_ff @(posedge clkResult or negedge arstN) begin
        if (!arstN) begin
            y <= '0;
        end else begin
            y <= total;
        end
    end

endmodule

/* hdl/RecursionFxp.sv */
`timescale 1ns/1ps

module RecursionFxp #(
    parameter int row = 0
) (
    input  logic           clkResult,
    input  logic           arstN,
    input  logic           enable,
    input  FxpPkg::CplxFxp x,
    output FxpPkg::CplxFxp state
);

    localparam FxpPkg::CplxFxp factor = RecursionPkg::lookbackFactor[row];

    FxpPkg::CplxFxp nextState;

    // state = x + L * state
    assign nextState = FxpPkg::cAdd(x, FxpPkg::cMul(factor, state));

    always_ff @(posedge clkResult or negedge arstN) begin
        if (!arstN) begin
            state <= '0;
        end else if (enable) begin
            state <= nextState;
        end
    end

endmodule

/* hdl/SumFxp.sv */
`timescale 1ns/1ps

module SumFxp #(
    parameter int numRows = 4
) (
    input  logic            clkResult,
    input  logic            arstN,
    input  FxpPkg::FxpValue terms [numRows],
    output FxpPkg::FxpValue total
);

    localparam int numLeaves = 1 << $clog2(numRows);

    // Heap-ordered adder tree, leaves start at numLeaves-1
    FxpPkg::FxpValue node [2*numLeaves-1];

    for (genvar i = 0; i < numLeaves; i++) begin : gLeaf
        if (i < numRows) begin : gTerm
            assign node[numLeaves-1+i] = terms[i];
        end else begin : gPad
            assign node[numLeaves-1+i] = '0;
        end
    end

    for (genvar n = 0; n < numLeaves - 1; n++) begin : gNode
        assign node[n] = node[2*n+1] + node[2*n+2];
    end

    always_ff @(posedge clkResult or negedge arstN) begin
        if (!arstN) begin
            total <= '0;
        end else begin
            total <= node[0];
        end
    end

endmodule

/* hdl/LookbackRecursion.sv */
`timescale 1ns/1ps

module LookbackRecursion #(
    parameter int numRows = 4,
    parameter int numCtrl = 4,
    parameter int downSample = 3,
    parameter int lutSize = 4,
    localparam int sampleBits = numCtrl * downSample
) (
    input  logic                  clkResult,
    input  logic                  arstN,
    input  logic [sampleBits-1:0] sample,
    input  logic                  sampleValid,
    output FxpPkg::FxpValue       result,
    output logic                  resultValid
);

    // One valid stage per data register: LUT, recursion, weight, sum
    logic [3:0] validPipe;

    FxpPkg::CplxFxp lutOut [numRows];
    FxpPkg::CplxFxp rowState [numRows];
    FxpPkg::CplxFxp weighted [numRows];
    FxpPkg::FxpValue rowRe [numRows];

    always_ff @(posedge clkResult or negedge arstN) begin
        if (!arstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[2:0], sampleValid};
        end
    end

    assign resultValid = validPipe[3];

    for (genvar i = 0; i < numRows; i++) begin : gRow
        LutUnit #(
            .row       (i),
            .numCtrl   (numCtrl),
            .downSample(downSample),
            .lutSize   (lutSize)
        ) i_LutUnit (
            .clkResult(clkResult),
            .arstN    (arstN),
            .sample   (sample),
            .y        (lutOut[i])
        );

        // Lookup output of an accepted sample is ready when stage 1 is set
        RecursionFxp #(
            .row(i)
        ) i_RecursionFxp (
            .clkResult(clkResult),
            .arstN    (arstN),
            .enable   (validPipe[0]),
            .x        (lutOut[i]),
            .state    (rowState[i])
        );

        ComplexFxpUnit #(
            .op(FxpPkg::opMult)
        ) i_ComplexFxpUnit (
            .clkResult(clkResult),
            .arstN    (arstN),
            .a        (rowState[i]),
            .b        (RecursionPkg::outputWeight[i]),
            .y        (weighted[i])
        );

        assign rowRe[i] = weighted[i].re;
    end

    SumFxp #(
        .numRows(numRows)
    ) i_SumFxp (
        .clkResult(clkResult),
        .arstN    (arstN),
        .terms    (rowRe),
        .total    (result)
    );

endmodule

/* test/LookbackRecursion_properties.sv */
`timescale 1ns/1ps

module LookbackRecursion_properties (
    input logic            clkResult,
    input logic            arstN,
    input logic            sampleValid,
    input logic            resultValid,
    input FxpPkg::FxpValue result
);

    // Four stages of latency, once the pipeline has been out of reset long enough
    validLatency: assert property (@(posedge clkResult) disable iff (!arstN)
        ($past(arstN, 1) && $past(arstN, 2) && $past(arstN, 3) && $past(arstN, 4))
            |-> (resultValid == $past(sampleValid, 4)))
        else $error("resultValid does not follow sampleValid by four cycles");

    quietInReset: assert property (@(posedge clkResult) !arstN |-> !resultValid)
        else $error("resultValid high during reset");

    knownResult: assert property (@(posedge clkResult) disable iff (!arstN)
        resultValid |-> !$isunknown(result))
        else $error("result has unknown bits while valid");

endmodule

bind LookbackRecursion LookbackRecursion_properties i_LookbackRecursionProperties (
    .clkResult  (clkResult),
    .arstN      (arstN),
    .sampleValid(sampleValid),
    .resultValid(resultValid),
    .result     (result)
);

/* test/LookbackRecursionTb.sv */
`timescale 1ns/1ps

module LookbackRecursionTb;

    localparam int numRows = 4;
    localparam int numCtrl = 4;
    localparam int downSample = 3;
    localparam int sampleBits = numCtrl * downSample;
    localparam int clkPeriod = 40;
    localparam int resetCycles = 8;
    localparam int numBurst = 200;
    localparam int numGapped = 120;
    localparam int maxGap = 3;
    localparam int numPreReset = 50;
    localparam int resetHold = 3;
    localparam int numPostReset = 100;
    // Upper bound on the clock cycles that all tests together use
    localparam int totalSlots = resetCycles + 4 + 20 + numBurst + 10
        + numGapped * (maxGap + 1) + 10 + numPreReset + resetHold + numPostReset + 10;

    logic clkResult = 1'b0;
    logic arstN;
    logic [sampleBits-1:0] sample;
    logic sampleValid;
    FxpPkg::FxpValue result;
    logic resultValid;

    FxpPkg::CplxFxp modelState [numRows];
    FxpPkg::FxpValue expectQ [$];
    int expectCycleQ [$];
    int cycleCount;
    int resultCount;
    int sentCount;
    int droppedCount;
    int errorCount;
    integer seed;

    LookbackRecursion i_LookbackRecursion (
        .clkResult  (clkResult),
        .arstN      (arstN),
        .sample     (sample),
        .sampleValid(sampleValid),
        .result     (result),
        .resultValid(resultValid)
    );

    always #(clkPeriod / 2) clkResult = ~clkResult;

    always @(posedge clkResult) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic failRun(string msg);
        errorCount++;
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("ERR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // Each bit adds +F when set and -F when clear once the control vectors are reversed
    function automatic FxpPkg::FxpValue modelStep(logic [sampleBits-1:0] s);
        logic [sampleBits-1:0] rev;
        FxpPkg::CplxFxp u;
        FxpPkg::CplxFxp f;
        FxpPkg::CplxFxp w;
        FxpPkg::FxpValue acc;
        for (int j = 0; j < downSample; j++) begin
            for (int c = 0; c < numCtrl; c++) begin
                rev[j*numCtrl+c] = s[(downSample-1-j)*numCtrl+c];
            end
        end
        acc = '0;
        for (int r = 0; r < numRows; r++) begin
            u = '0;
            for (int i = 0; i < sampleBits; i++) begin
                f = RecursionPkg::inputWeight(r, i);
                if (!rev[i]) begin
                    f.re = -f.re;
                    f.im = -f.im;
                end
                u = FxpPkg::cAdd(u, f);
            end
            modelState[r] = FxpPkg::cAdd(u,
                FxpPkg::cMul(RecursionPkg::lookbackFactor[r], modelState[r]));
            w = FxpPkg::cMul(modelState[r], RecursionPkg::outputWeight[r]);
            acc = acc + w.re;
        end
        return acc;
    endfunction

    task automatic resetModel();
        for (int r = 0; r < numRows; r++) begin
            modelState[r] = '0;
        end
        droppedCount += expectQ.size();
        expectQ.delete();
        expectCycleQ.delete();
    endtask

    // Result is due five counts after the driving edge
    task automatic sendSample(logic [sampleBits-1:0] value);
        @(posedge clkResult);
        sample <= value;
        sampleValid <= 1'b1;
        expectQ.push_back(modelStep(value));
        expectCycleQ.push_back(cycleCount + 5);
        sentCount++;
    endtask

    task automatic idleCycles(int n);
        repeat (n) begin
            @(posedge clkResult);
            sampleValid <= 1'b0;
        end
    endtask

    task automatic sendRandom();
        logic [31:0] rnd;
        rnd = $random(seed);
        sendSample(rnd[sampleBits-1:0]);
    endtask

    task automatic waitDrained();
        while (expectQ.size() != 0) begin
            @(negedge clkResult);
        end
    endtask

    task automatic applyReset(int holdCycles);
        @(posedge clkResult);
        arstN <= 1'b0;
        sampleValid <= 1'b0;
        resetModel();
        repeat (holdCycles) @(posedge clkResult);
        arstN <= 1'b1;
    endtask

    // Outputs are compared on the falling edge
    initial begin
        forever begin
            @(negedge clkResult);
            if (resultValid === 1'b1) begin
                if (expectQ.size() == 0) begin
                    failRun("A result arrived while no sample was outstanding");
                end else begin
                    checkValue("resultCycle", cycleCount, expectCycleQ.pop_front());
                    checkValue("result", result, expectQ.pop_front());
                    resultCount++;
                end
            end
        end
    end

    initial begin
        #(longint'(totalSlots + 20) * clkPeriod);
        failRun("Timeout: results stopped arriving before all samples were checked");
    end

    initial begin
        logic [31:0] rnd;
        seed = 32'h1120;
        arstN = 1'b0;
        sample = '0;
        sampleValid = 1'b0;
        cycleCount = 0;
        resultCount = 0;
        sentCount = 0;
        droppedCount = 0;
        errorCount = 0;
        resetModel();
        repeat (resetCycles) @(posedge clkResult);
        arstN <= 1'b1;

        // Quiet outputs right after reset
        repeat (4) begin
            @(negedge clkResult);
            checkValue("resultValid", 32'(resultValid), 32'd0);
            checkValue("result", result, 32'd0);
        end

        // One sample of all ones gives exactly one result
        sendSample('1);
        idleCycles(1);
        waitDrained();
        idleCycles(8);
        checkValue("resultCount", resultCount, 32'd1);

        repeat (numBurst) sendRandom();
        idleCycles(1);
        waitDrained();

        // Gaps must leave the recursion states untouched
        repeat (numGapped) begin
            sendRandom();
            rnd = $random(seed);
            idleCycles(int'(rnd[1:0]));
        end
        idleCycles(1);
        waitDrained();

        repeat (numPreReset) sendRandom();
        applyReset(resetHold);
        repeat (numPostReset) sendRandom();
        idleCycles(1);
        waitDrained();
        idleCycles(8);
        checkValue("resultCount", resultCount, sentCount - droppedCount);

        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/FxpPkg.sv
hdl/RecursionPkg.sv
hdl/ComplexFxpUnit.sv
hdl/LutUnit.sv
hdl/RecursionFxp.sv
hdl/SumFxp.sv
hdl/LookbackRecursion.sv
test/LookbackRecursion_properties.sv
test/LookbackRecursionTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= LookbackRecursionTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
PASS_TEXT ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
